/* all.f */
hw/alu_pkg.sv
hw/alu_issue.sv
hw/ma_unit.sv
hw/idiv_unit.sv
hw/bitops_unit.sv
hw/alu_exec.sv
hw/alu_result.sv
hw/alu_top.sv
verif/clk_gen.sv
verif/tb_alu.sv

/* run.sh */
#!/usr/bin/env bash
set -eo pipefail

cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal --top-module tb_alu -f all.f -o sim_alu
./obj_dir/sim_alu | tee sim.log

if grep -q "Simulation FAILED" sim.log; then
	echo "run.sh: testbench reported a failure, see sim.log"
	exit 1
fi
echo "run.sh: no failure reported"

/* verif/tb_alu.sv */
`timescale 1ns/1ps

module tb_alu;

	localparam int TIMEOUT = 200;
	localparam int MAX_ROWS = 48;
	localparam int MAX_TESTS = 8;

	logic                          clock, rst_n;
	logic                          req, ack, res_req, res_ack;
	alu_pkg::alu_op_e              op;
	logic [alu_pkg::DATA_W-1:0]    a, b, c, res_data;
	logic [alu_pkg::TAG_W-1:0]     res_tag;

	// Stimulus table
	alu_pkg::alu_op_e              t_op [MAX_ROWS];
	logic [alu_pkg::DATA_W-1:0]    t_a [MAX_ROWS];
	logic [alu_pkg::DATA_W-1:0]    t_b [MAX_ROWS];
	logic [alu_pkg::DATA_W-1:0]    t_c [MAX_ROWS];
	logic [alu_pkg::DATA_W-1:0]    t_exp [MAX_ROWS];
	int                            n_rows, n_tests;
	int                            test_first [MAX_TESTS];
	int                            test_cnt [MAX_TESTS];
	string                         test_name [MAX_TESTS];
	logic                          test_slow [MAX_TESTS];  // Random res_ack delay

	// Scoreboard indexed by tag
	logic                          tag_busy [1<<alu_pkg::TAG_W];
	int                            tag_row [1<<alu_pkg::TAG_W];
	logic [alu_pkg::TAG_W-1:0]     pred_tag, last_tag;
	int                            errors, n_checks;
	logic                          abort;
	logic [15:0]                   lfsr;
	logic                          ack_q = 1'b0;
	logic                          res_req_q = 1'b0;
	logic                          res_ack_q = 1'b0;
	logic                          req_q = 1'b0;

	clk_gen i_clk_gen (.clock(clock), .rst_n(rst_n));

	alu_top i_alu_top (
		.clock(clock), .rst_n(rst_n),
		.req(req), .ack(ack), .op(op), .a(a), .b(b), .c(c),
		.res_req(res_req), .res_ack(res_ack), .res_data(res_data), .res_tag(res_tag)
	);

	//////////////////////////////////////////////////
	// Random bits and reference model
	//////////////////////////////////////////////////
	function automatic logic [15:0] lfsr_step(input logic [15:0] s);
		return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};  // x^16+x^14+x^13+x^11+1
	endfunction

	task automatic take_bits(input int n, output logic [31:0] v);
		v = '0;
		for (int i = 0; i < n; i++) begin
			lfsr = lfsr_step(lfsr);
			v = {v[30:0], lfsr[0]};
		end
	endtask

	function automatic logic [31:0] ref_result(input logic [3:0] code,
		input logic [31:0] x, input logic [31:0] y, input logic [31:0] z);
		int s;
		s = y % 32;
		case (code)
			4'h1: return x - y;
			4'h2: return x * y;
			4'h3: return x * y + z;
			4'h4: return (y == 0) ? 32'hFFFF_FFFF : x / y;
			4'h5: return (y == 0) ? x : x % y;
			4'h6: return x << s;
			4'h7: return x >> s;
			4'h8: return $signed(x) >>> s;
			4'h9: return (x << s) | (x >> (32 - s));
			4'hA: return x & y;
			4'hB: return x | y;
			4'hC: return x ^ y;
			4'hD: return {{24{x[7]}}, x[7:0]};
			4'hE: return {{16{x[15]}}, x[15:0]};
			default: return x + y;  // ADD and the spare code
		endcase
	endfunction

	task automatic begin_test(input string name, input logic slow);
		test_name[n_tests]  = name;
		test_first[n_tests] = n_rows;
		test_cnt[n_tests]   = 0;
		test_slow[n_tests]  = slow;
		n_tests++;
	endtask

	task automatic add_row(input alu_pkg::alu_op_e o, input logic [31:0] x,
		input logic [31:0] y, input logic [31:0] z, input logic [31:0] e);
		t_op[n_rows]  = o;
		t_a[n_rows]   = x;
		t_b[n_rows]   = y;
		t_c[n_rows]   = z;
		t_exp[n_rows] = e;
		n_rows++;
		test_cnt[n_tests-1]++;
	endtask

	task automatic add_random_row();
		logic [31:0] o, x, y, z;
		take_bits(4, o);
		take_bits(32, x);
		take_bits(32, y);
		take_bits(32, z);
		add_row(alu_pkg::alu_op_e'(o[3:0]), x, y, z, ref_result(o[3:0], x, y, z));
	endtask

	task automatic fill_table();
		begin_test("reset state", 1'b0);
		add_row(alu_pkg::ADD, 32'd5, 32'd7, 32'd99, 32'd12);
		begin_test("multiply-add", 1'b0);
		add_row(alu_pkg::ADD, 32'hFFFF_FFFF, 32'd2, 32'd0, 32'd1);  // Wraps
		add_row(alu_pkg::SUB, 32'd3, 32'd5, 32'd0, 32'hFFFF_FFFE);
		add_row(alu_pkg::MUL, 32'd1000, 32'd1000, 32'd7, 32'h000F_4240);
		add_row(alu_pkg::MUL, 32'hFFFF_FFFF, 32'hFFFF_FFFF, 32'd0, 32'd1);
		add_row(alu_pkg::MUL, 32'h0001_0000, 32'h0001_0000, 32'd0, 32'd0);
		add_row(alu_pkg::MADD, 32'h0001_0001, 32'h0001_0001, 32'd5, 32'h0002_0006);
		add_row(alu_pkg::MADD, 32'd7, 32'd6, 32'hFFFF_FFFF, 32'h0000_0029);
		add_row(alu_pkg::alu_op_e'(4'hF), 32'h100, 32'h23, 32'h55, 32'h123);
		begin_test("divider", 1'b0);
		add_row(alu_pkg::DIVU, 32'd100, 32'd7, 32'd0, 32'd14);
		add_row(alu_pkg::REMU, 32'd100, 32'd7, 32'd0, 32'd2);
		add_row(alu_pkg::DIVU, 32'hFFFF_FFFF, 32'd1, 32'd0, 32'hFFFF_FFFF);
		add_row(alu_pkg::DIVU, 32'h8000_0000, 32'd3, 32'd0, 32'h2AAA_AAAA);
		add_row(alu_pkg::REMU, 32'h8000_0000, 32'd3, 32'd0, 32'd2);
		add_row(alu_pkg::DIVU, 32'd5, 32'd9, 32'd0, 32'd0);
		add_row(alu_pkg::DIVU, 32'h1234, 32'd0, 32'd0, 32'hFFFF_FFFF);  // By zero
		add_row(alu_pkg::REMU, 32'h1234, 32'd0, 32'd0, 32'h1234);
		begin_test("bit operations", 1'b0);
		add_row(alu_pkg::SHL, 32'd1, 32'd35, 32'd0, 32'd8);
		add_row(alu_pkg::SHR, 32'h8000_0000, 32'd31, 32'd0, 32'd1);
		add_row(alu_pkg::SRA, 32'h8000_0000, 32'd4, 32'd0, 32'hF800_0000);
		add_row(alu_pkg::SRA, 32'h4000_0000, 32'h41, 32'd0, 32'h2000_0000);
		add_row(alu_pkg::ROL, 32'h8000_0001, 32'd1, 32'd0, 32'h0000_0003);
		add_row(alu_pkg::ROL, 32'h1234_5678, 32'd8, 32'd0, 32'h3456_7812);
		add_row(alu_pkg::ROL, 32'hDEAD_BEEF, 32'd32, 32'd0, 32'hDEAD_BEEF);
		add_row(alu_pkg::AND, 32'hF0F0_F0F0, 32'hFF00_FF00, 32'd0, 32'hF000_F000);
		add_row(alu_pkg::OR, 32'hF0F0_F0F0, 32'h0F0F_0000, 32'd0, 32'hFFFF_F0F0);
		add_row(alu_pkg::XOR, 32'hFFFF_0000, 32'h0FF0_0FF0, 32'd0, 32'hF00F_0FF0);
		add_row(alu_pkg::SEXT_B, 32'h1234_5680, 32'd0, 32'd0, 32'hFFFF_FF80);
		add_row(alu_pkg::SEXT_B, 32'h0000_007F, 32'd0, 32'd0, 32'h0000_007F);
		add_row(alu_pkg::SEXT_H, 32'h0001_8000, 32'd0, 32'd0, 32'hFFFF_8000);
		begin_test("out-of-order", 1'b0);
		add_row(alu_pkg::DIVU, 32'd1000, 32'd10, 32'd0, 32'd100);  // Slow one first
		add_row(alu_pkg::ADD, 32'd1, 32'd2, 32'd0, 32'd3);
		add_row(alu_pkg::AND, 32'hFF, 32'h0F, 32'd0, 32'h0F);
		begin_test("back-pressure", 1'b1);
		repeat (12) add_random_row();
	endtask

	//////////////////////////////////////////////////
	// Bounded waits
	//////////////////////////////////////////////////
	task automatic wait_rst_release();
		int n;
		n = 0;
		while (!rst_n && n < TIMEOUT) begin
			@(negedge clock);
			n++;
		end
		if (!rst_n) begin
			$display("Reset was never released within %0d cycles", TIMEOUT);
			abort = 1'b1;
		end
		@(posedge clock);
		#1;
	endtask

	task automatic wait_ack(input logic level);
		int n;
		n = 0;
		while (ack !== level && n < TIMEOUT && !abort) begin
			@(posedge clock);
			#1;
			n++;
		end
		if (ack !== level && !abort) begin
			$display("Timed out after %0d cycles waiting for ack to become %0d", n, level);
			abort = 1'b1;
		end
	endtask

	task automatic wait_res_req(input logic level);
		int n;
		n = 0;
		while (res_req !== level && n < TIMEOUT && !abort) begin
			@(posedge clock);
			#1;
			n++;
		end
		if (res_req !== level && !abort) begin
			$display("Timed out after %0d cycles waiting for res_req to become %0d", n, level);
			abort = 1'b1;
		end
	endtask

	//////////////////////////////////////////////////
	// Handshake drivers
	//////////////////////////////////////////////////
	task automatic send_rows(input int first, input int cnt);
		for (int r = first; r < first + cnt && !abort; r++) begin
			op  = t_op[r];  // Both req and ack are low here
			a   = t_a[r];
			b   = t_b[r];
			c   = t_c[r];
			req = 1'b1;
			wait_ack(1'b1);
			if (abort)
				break;
			assert (!tag_busy[pred_tag]) else begin
				$display("Issue number %0h was reused while still outstanding", pred_tag);
				errors++;
			end
			tag_busy[pred_tag] = 1'b1;
			tag_row[pred_tag]  = r;
			pred_tag           = pred_tag + 1'b1;
			req                = 1'b0;
			wait_ack(1'b0);
		end
	endtask

	task automatic receive_rows(input int cnt, input logic slow);
		logic [31:0]               d;
		logic [alu_pkg::TAG_W-1:0] tag;
		int                        row;
		for (int i = 0; i < cnt && !abort; i++) begin
			wait_res_req(1'b1);
			if (abort)
				break;
			tag      = res_tag;
			last_tag = tag;
			n_checks++;
			assert (tag_busy[tag]) else begin
				$display("Result came back with tag %0h, which is not outstanding", tag);
				errors++;
			end
			if (tag_busy[tag]) begin
				row = tag_row[tag];
				assert (res_data == t_exp[row]) else begin
					$display("CHECK FAILED res_data (tag %0h, row %0d): got %08h expected %08h",
						tag, row, res_data, t_exp[row]);
					errors++;
				end
				tag_busy[tag] = 1'b0;
			end
			d = 0;
			if (slow)
				take_bits(4, d);  // 0 to 15 cycles
			repeat (d) begin
				@(posedge clock);
				#1;
			end
			res_ack = 1'b1;
			wait_res_req(1'b0);
			res_ack = 1'b0;
		end
	endtask

	// Protocol monitor on the falling edge
	always @(negedge clock) begin
		if (rst_n) begin
			assert (!(ack && !ack_q && !req_q)) else begin
				$display("ack rose although req was low");
				errors++;
			end
			assert (!(res_req_q && !res_req && !res_ack_q)) else begin
				$display("res_req fell before res_ack was raised");
				errors++;
			end
		end
		ack_q     = ack;
		req_q     = req;
		res_req_q = res_req;
		res_ack_q = res_ack;
	end

	initial begin
		int err0;
		req      = 1'b0;
		res_ack  = 1'b0;
		op       = alu_pkg::ADD;
		a        = '0;
		b        = '0;
		c        = '0;
		errors   = 0;
		n_checks = 0;
		n_rows   = 0;
		n_tests  = 0;
		abort    = 1'b0;
		pred_tag = '0;
		last_tag = '1;
		lfsr     = 16'd36677;
		for (int i = 0; i < (1 << alu_pkg::TAG_W); i++) begin
			tag_busy[i] = 1'b0;
			tag_row[i]  = 0;
		end
		fill_table();
		wait_rst_release();

		for (int t = 0; t < n_tests && !abort; t++) begin
			err0 = errors;
			if (t == 0) begin
				assert (ack == 1'b0) else begin
					$display("CHECK FAILED ack after reset: got %0h expected 0", ack);
					errors++;
				end
				assert (res_req == 1'b0) else begin
					$display("CHECK FAILED res_req after reset: got %0h expected 0", res_req);
					errors++;
				end
			end
			fork
				send_rows(test_first[t], test_cnt[t]);
				receive_rows(test_cnt[t], test_slow[t]);
			join
			if (t == 0) begin
				assert (last_tag == '0) else begin
					$display("CHECK FAILED res_tag of first result: got %0h expected 0", last_tag);
					errors++;
				end
			end
			$display("test %0d %s: %0d rows, %s", t, test_name[t], test_cnt[t],
				(errors == err0 && !abort) ? "ok" : "failed");
		end

		// Nothing more may come back
		if (!abort) begin
			repeat (10) begin
				@(posedge clock);
				#1;
				assert (!res_req) else begin
					$display("An extra result with tag %0h came back", res_tag);
					errors++;
				end
			end
		end

		$display("results checked %0d, errors %0d, aborted %0d", n_checks, errors, abort);
		if (errors == 0 && !abort)
			$display("Simulation PASSED");
		else
			$display("Simulation FAILED");
		$finish;
	end

endmodule

/* verif/clk_gen.sv */
`timescale 1ns/1ps

module clk_gen (
	output logic clock,
	output logic rst_n
);

	initial begin
		clock = 1'b0;
		rst_n = 1'b0;
		repeat (2) @(posedge clock);
		#1 rst_n = 1'b1;  // Two full cycles in reset
	end

	always #20 clock = ~clock;  // 40 ns period

endmodule

/* hw/alu_top.sv */
`timescale 1ns/1ps

module alu_top (
	input  logic                          clock,
	input  logic                          rst_n,
	input  logic                          req,
	output logic                          ack,
	input  alu_pkg::alu_op_e              op,
	input  logic [alu_pkg::DATA_W-1:0]    a,
	input  logic [alu_pkg::DATA_W-1:0]    b,
	input  logic [alu_pkg::DATA_W-1:0]    c,
	output logic                          res_req,
	input  logic                          res_ack,
	output logic [alu_pkg::DATA_W-1:0]    res_data,
	output logic [alu_pkg::TAG_W-1:0]     res_tag
);

	// Issue to execute
	logic                          iss_valid, iss_ready;
	alu_pkg::alu_op_e              iss_op;
	logic [alu_pkg::DATA_W-1:0]    iss_a, iss_b, iss_c;
	logic [alu_pkg::TAG_W-1:0]     iss_tag;
	// Execute to result
	logic                          wb_valid, wb_ready;
	logic [alu_pkg::DATA_W-1:0]    wb_data;
	logic [alu_pkg::TAG_W-1:0]     wb_tag;

	alu_issue u_issue (
		.clock(clock), .rst_n(rst_n),
		.req(req), .ack(ack), .op(op), .a(a), .b(b), .c(c),
		.iss_valid(iss_valid), .iss_ready(iss_ready), .iss_op(iss_op),
		.iss_a(iss_a), .iss_b(iss_b), .iss_c(iss_c), .iss_tag(iss_tag)
	);

	alu_exec u_exec (
		.clock(clock), .rst_n(rst_n),
		.iss_valid(iss_valid), .iss_ready(iss_ready), .iss_op(iss_op),
		.iss_a(iss_a), .iss_b(iss_b), .iss_c(iss_c), .iss_tag(iss_tag),
		.wb_valid(wb_valid), .wb_ready(wb_ready), .wb_data(wb_data), .wb_tag(wb_tag)
	);

	alu_result u_result (
		.clock(clock), .rst_n(rst_n),
		.wb_valid(wb_valid), .wb_ready(wb_ready), .wb_data(wb_data), .wb_tag(wb_tag),
		.res_req(res_req), .res_ack(res_ack), .res_data(res_data), .res_tag(res_tag)
	);

endmodule

/* hw/alu_result.sv */
`timescale 1ns/1ps

module alu_result (
	input  logic                          clock,
	input  logic                          rst_n,
	input  logic                          wb_valid,
	output logic                          wb_ready,
	input  logic [alu_pkg::DATA_W-1:0]    wb_data,
	input  logic [alu_pkg::TAG_W-1:0]     wb_tag,
	output logic                          res_req,
	input  logic                          res_ack,
	output logic [alu_pkg::DATA_W-1:0]    res_data,
	output logic [alu_pkg::TAG_W-1:0]     res_tag
);

	typedef enum logic [1:0] {EMPTY, SEND, WAIT_LOW} state_e;

	state_e state;

	assign wb_ready = (state == EMPTY);
	assign res_req  = (state == SEND);

	always_ff @(posedge clock) begin
		if (!rst_n)
			state <= EMPTY;
		else case (state)
			EMPTY:    if (wb_valid) state <= SEND;
			SEND:     if (res_ack) state <= WAIT_LOW;   // Sink has the data
			WAIT_LOW: if (!res_ack) state <= EMPTY;
			default:  state <= EMPTY;
		endcase
	end

	always_ff @(posedge clock) begin
		if (wb_valid && wb_ready) begin
			res_data <= wb_data;
			res_tag  <= wb_tag;
		end
	end

	a_data_stable: assert property (@(posedge clock) disable iff (!rst_n)
		res_req && $past(res_req) |-> $stable(res_data));

endmodule

/* hw/alu_exec.sv */
`timescale 1ns/1ps

module alu_exec (
	input  logic                          clock,
	input  logic                          rst_n,
	input  logic                          iss_valid,
	output logic                          iss_ready,
	input  alu_pkg::alu_op_e              iss_op,
	input  logic [alu_pkg::DATA_W-1:0]    iss_a,
	input  logic [alu_pkg::DATA_W-1:0]    iss_b,
	input  logic [alu_pkg::DATA_W-1:0]    iss_c,
	input  logic [alu_pkg::TAG_W-1:0]     iss_tag,
	output logic                          wb_valid,
	input  logic                          wb_ready,
	output logic [alu_pkg::DATA_W-1:0]    wb_data,
	output logic [alu_pkg::TAG_W-1:0]     wb_tag
);

	alu_pkg::unit_e                              tgt, sel;
	logic [$clog2(alu_pkg::MAX_IN_FLIGHT+1)-1:0] cnt;
	logic [(1<<alu_pkg::TAG_W)-1:0]              pend;   // Outstanding tags
	logic [alu_pkg::TAG_W-1:0]                   base, next_tag;
	logic [alu_pkg::TAG_W-1:0]                   age_ma, age_div, age_bit, best_age;
	logic                                        room, dispatch, wb_fire, found;
	logic                                        ma_iv, div_iv, bit_iv;
	logic                                        ma_rdy, div_rdy, bit_rdy;
	logic                                        ma_ov, div_ov, bit_ov;
	logic                                        ma_take, div_take, bit_take;
	logic [alu_pkg::DATA_W-1:0]                  ma_data, div_data, bit_data;
	logic [alu_pkg::TAG_W-1:0]                   ma_tag, div_tag, bit_tag;

	//////////////////////////////////////////////////
	// Dispatch
	//////////////////////////////////////////////////
	always_comb begin
		case (iss_op)
			alu_pkg::DIVU, alu_pkg::REMU: tgt = alu_pkg::UNIT_DIV;
			alu_pkg::ADD, alu_pkg::SUB,
			alu_pkg::MUL, alu_pkg::MADD:  tgt = alu_pkg::UNIT_MA;
			alu_pkg::SHL, alu_pkg::SHR, alu_pkg::SRA, alu_pkg::ROL,
			alu_pkg::AND, alu_pkg::OR, alu_pkg::XOR,
			alu_pkg::SEXT_B, alu_pkg::SEXT_H: tgt = alu_pkg::UNIT_BIT;
			default:                      tgt = alu_pkg::UNIT_MA;  // Spare code runs as ADD
		endcase
	end

	assign room      = cnt < alu_pkg::MAX_IN_FLIGHT;
	assign ma_iv     = iss_valid && room && tgt == alu_pkg::UNIT_MA;
	assign div_iv    = iss_valid && room && tgt == alu_pkg::UNIT_DIV;
	assign bit_iv    = iss_valid && room && tgt == alu_pkg::UNIT_BIT;
	assign iss_ready = room && ((tgt == alu_pkg::UNIT_MA && ma_rdy) ||
		(tgt == alu_pkg::UNIT_DIV && div_rdy) || (tgt == alu_pkg::UNIT_BIT && bit_rdy));
	assign dispatch  = iss_valid && iss_ready;
	assign wb_fire   = wb_valid && wb_ready;

	// In-flight count and age base
	always_ff @(posedge clock) begin
		if (!rst_n) begin
			cnt      <= '0;
			pend     <= '0;
			base     <= '0;
			next_tag <= '0;
		end else begin
			if (dispatch) begin
				pend[iss_tag] <= 1'b1;
				next_tag      <= iss_tag + 1'b1;
			end
			if (wb_fire)
				pend[wb_tag] <= 1'b0;
			if (base != next_tag && !pend[base])  // Walk past returned tags
				base <= base + 1'b1;
			case ({dispatch, wb_fire})
				2'b10:   cnt <= cnt + 1'b1;
				2'b01:   cnt <= cnt - 1'b1;
				default: ;
			endcase
		end
	end

	//////////////////////////////////////////////////
	// Oldest-first write-back select
	//////////////////////////////////////////////////
	assign age_ma  = ~(ma_tag - base);  // Nearest to base is largest
	assign age_div = ~(div_tag - base);
	assign age_bit = ~(bit_tag - base);

	always_comb begin
		sel      = alu_pkg::UNIT_MA;
		best_age = age_ma;
		found    = ma_ov;
		if (div_ov && (!found || age_div > best_age)) begin
			sel      = alu_pkg::UNIT_DIV;
			best_age = age_div;
			found    = 1'b1;
		end
		if (bit_ov && (!found || age_bit > best_age)) begin
			sel      = alu_pkg::UNIT_BIT;
			best_age = age_bit;
			found    = 1'b1;
		end
	end

	assign wb_valid = found;
	assign wb_data  = sel == alu_pkg::UNIT_DIV ? div_data :
		sel == alu_pkg::UNIT_BIT ? bit_data : ma_data;
	assign wb_tag   = sel == alu_pkg::UNIT_DIV ? div_tag :
		sel == alu_pkg::UNIT_BIT ? bit_tag : ma_tag;
	assign ma_take  = wb_fire && sel == alu_pkg::UNIT_MA;
	assign div_take = wb_fire && sel == alu_pkg::UNIT_DIV;
	assign bit_take = wb_fire && sel == alu_pkg::UNIT_BIT;

	ma_unit u_ma (
		.clock(clock), .rst_n(rst_n),
		.in_valid(ma_iv), .in_ready(ma_rdy), .in_op(iss_op),
		.in_a(iss_a), .in_b(iss_b), .in_c(iss_c), .in_tag(iss_tag),
		.out_valid(ma_ov), .out_data(ma_data), .out_tag(ma_tag), .out_take(ma_take)
	);

	idiv_unit u_div (
		.clock(clock), .rst_n(rst_n),
		.in_valid(div_iv), .in_ready(div_rdy), .in_op(iss_op),
		.in_a(iss_a), .in_b(iss_b), .in_tag(iss_tag),
		.out_valid(div_ov), .out_data(div_data), .out_tag(div_tag), .out_take(div_take)
	);

	bitops_unit u_bit (
		.clock(clock), .rst_n(rst_n),
		.in_valid(bit_iv), .in_ready(bit_rdy), .in_op(iss_op),
		.in_a(iss_a), .in_b(iss_b), .in_tag(iss_tag),
		.out_valid(bit_ov), .out_data(bit_data), .out_tag(bit_tag), .out_take(bit_take)
	);

	a_cnt_limit: assert property (@(posedge clock) disable iff (!rst_n)
		cnt <= alu_pkg::MAX_IN_FLIGHT);
	a_one_take: assert property (@(posedge clock) disable iff (!rst_n)
		$onehot0({ma_take, div_take, bit_take}));

endmodule

/* hw/bitops_unit.sv */
`timescale 1ns/1ps

module bitops_unit (
	input  logic                          clock,
	input  logic                          rst_n,
	input  logic                          in_valid,
	output logic                          in_ready,
	input  alu_pkg::alu_op_e              in_op,
	input  logic [alu_pkg::DATA_W-1:0]    in_a,
	input  logic [alu_pkg::DATA_W-1:0]    in_b,
	input  logic [alu_pkg::TAG_W-1:0]     in_tag,
	output logic                          out_valid,
	output logic [alu_pkg::DATA_W-1:0]    out_data,
	output logic [alu_pkg::TAG_W-1:0]     out_tag,
	input  logic                          out_take
);

	logic [$clog2(alu_pkg::DATA_W)-1:0]  sh;     // b mod 32
	logic [2*alu_pkg::DATA_W-1:0]        rol_w;
	logic [alu_pkg::DATA_W-1:0]          res;

	assign sh       = in_b[$clog2(alu_pkg::DATA_W)-1:0];
	assign rol_w    = {in_a, in_a} << sh;  // Upper half is the rotate
	assign in_ready = !out_valid || out_take;

	always_comb begin
		case (in_op)
			alu_pkg::SHL:    res = in_a << sh;
			alu_pkg::SHR:    res = in_a >> sh;
			alu_pkg::SRA:    res = $signed(in_a) >>> sh;
			alu_pkg::ROL:    res = rol_w[2*alu_pkg::DATA_W-1:alu_pkg::DATA_W];
			alu_pkg::AND:    res = in_a & in_b;
			alu_pkg::OR:     res = in_a | in_b;
			alu_pkg::XOR:    res = in_a ^ in_b;
			alu_pkg::SEXT_B: res = {{(alu_pkg::DATA_W-8){in_a[7]}}, in_a[7:0]};
			alu_pkg::SEXT_H: res = {{(alu_pkg::DATA_W-16){in_a[15]}}, in_a[15:0]};
			default:         res = '0;  // Not routed here
		endcase
	end

	always_ff @(posedge clock) begin
		if (!rst_n)
			out_valid <= 1'b0;
		else if (in_valid && in_ready)
			out_valid <= 1'b1;
		else if (out_take)
			out_valid <= 1'b0;
	end

	// Hold register
	always_ff @(posedge clock) begin
		if (in_valid && in_ready) begin
			out_data <= res;
			out_tag  <= in_tag;
		end
	end

endmodule

/* hw/idiv_unit.sv */
`timescale 1ns/1ps

module idiv_unit (
	input  logic                          clock,
	input  logic                          rst_n,
	input  logic                          in_valid,
	output logic                          in_ready,
	input  alu_pkg::alu_op_e              in_op,
	input  logic [alu_pkg::DATA_W-1:0]    in_a,
	input  logic [alu_pkg::DATA_W-1:0]    in_b,
	input  logic [alu_pkg::TAG_W-1:0]     in_tag,
	output logic                          out_valid,
	output logic [alu_pkg::DATA_W-1:0]    out_data,
	output logic [alu_pkg::TAG_W-1:0]     out_tag,
	input  logic                          out_take
);

	typedef enum logic [1:0] {IDLE, RUN, DONE} state_e;

	state_e                       state;
	logic [5:0]                   step;
	logic [alu_pkg::DATA_W-1:0]   rem, quo, dvs, dvd;
	logic                         want_rem;

	// One restoring step, returns {rem, quo}
	function automatic logic [2*alu_pkg::DATA_W-1:0] div_step(
		input logic [alu_pkg::DATA_W-1:0] r,
		input logic [alu_pkg::DATA_W-1:0] q,
		input logic [alu_pkg::DATA_W-1:0] d
	);
		logic [alu_pkg::DATA_W:0] sh;
		logic [alu_pkg::DATA_W:0] diff;
		sh   = {r, q[alu_pkg::DATA_W-1]};
		diff = sh - {1'b0, d};
		if (diff[alu_pkg::DATA_W])  // Negative, restore
			return {sh[alu_pkg::DATA_W-1:0], q[alu_pkg::DATA_W-2:0], 1'b0};
		return {diff[alu_pkg::DATA_W-1:0], q[alu_pkg::DATA_W-2:0], 1'b1};
	endfunction

	assign in_ready  = (state == IDLE);
	assign out_valid = (state == DONE);

	always_ff @(posedge clock) begin
		if (!rst_n)
			state <= IDLE;
		else case (state)
			IDLE:    if (in_valid) state <= RUN;
			RUN:     if (step == 6'd32) state <= DONE;
			DONE:    if (out_take) state <= IDLE;
			default: state <= IDLE;
		endcase
	end

	//////////////////////////////////////////////////
	// Datapath, first step runs on the dispatch edge
	//////////////////////////////////////////////////
	always_ff @(posedge clock) begin
		if (state == IDLE && in_valid) begin
			{rem, quo} <= div_step('0, in_a, in_b);
			step       <= 6'd1;
			dvs        <= in_b;
			dvd        <= in_a;
			want_rem   <= (in_op == alu_pkg::REMU);
			out_tag    <= in_tag;
		end else if (state == RUN) begin
			if (step == 6'd32) begin
				// Final cycle
				if (dvs == '0)
					out_data <= want_rem ? dvd : '1;
				else
					out_data <= want_rem ? rem : quo;
			end else begin
				{rem, quo} <= div_step(rem, quo, dvs);
				step       <= step + 6'd1;
			end
		end
	end

endmodule

/* hw/ma_unit.sv */
`timescale 1ns/1ps

module ma_unit (
	input  logic                          clock,
	input  logic                          rst_n,
	input  logic                          in_valid,
	output logic                          in_ready,
	input  alu_pkg::alu_op_e              in_op,
	input  logic [alu_pkg::DATA_W-1:0]    in_a,
	input  logic [alu_pkg::DATA_W-1:0]    in_b,
	input  logic [alu_pkg::DATA_W-1:0]    in_c,
	input  logic [alu_pkg::TAG_W-1:0]     in_tag,
	output logic                          out_valid,
	output logic [alu_pkg::DATA_W-1:0]    out_data,
	output logic [alu_pkg::TAG_W-1:0]     out_tag,
	input  logic                          out_take
);

	logic [alu_pkg::MA_DEPTH-1:0]  v;    // One valid bit per stage
	logic                          adv;
	logic                          sel_byp;
	logic [alu_pkg::DATA_W-1:0]    sel_y;
	logic [alu_pkg::DATA_W-1:0]    sel_add;

	logic                          s1_byp;
	logic [alu_pkg::DATA_W-1:0]    s1_x, s1_y, s1_add;
	logic [alu_pkg::DATA_W-1:0]    s2_pl, s2_add;
	logic [15:0]                   s2_ph;
	logic [alu_pkg::DATA_W-1:0]    s3_prod, s3_add;
	logic [alu_pkg::TAG_W-1:0]     s1_tag, s2_tag, s3_tag;

	assign adv       = !v[alu_pkg::MA_DEPTH-1] || out_take;  // Whole pipe stalls otherwise
	assign in_ready  = adv;
	assign out_valid = v[alu_pkg::MA_DEPTH-1];

	// Operand select, ADD and SUB skip the multiplier
	always_comb begin
		sel_byp = 1'b1;
		sel_y   = in_b;
		sel_add = in_a;
		case (in_op)
			alu_pkg::SUB:  sel_y = -in_b;
			alu_pkg::MUL:  begin sel_byp = 1'b0; sel_add = '0; end
			alu_pkg::MADD: begin sel_byp = 1'b0; sel_add = in_c; end
			default: ;
		endcase
	end

	always_ff @(posedge clock) begin
		if (!rst_n)
			v <= '0;
		else if (adv)
			v <= {v[alu_pkg::MA_DEPTH-2:0], in_valid};
	end

	always_ff @(posedge clock) begin
		if (adv) begin
			s1_byp   <= sel_byp;
			s1_x     <= in_a;
			s1_y     <= sel_y;
			s1_add   <= sel_add;
			s1_tag   <= in_tag;
			s2_pl    <= s1_byp ? s1_y : s1_x * s1_y[15:0];  // Low partial
			s2_ph    <= s1_byp ? 16'd0 : s1_x[15:0] * s1_y[31:16];
			s2_add   <= s1_add;
			s2_tag   <= s1_tag;
			s3_prod  <= s2_pl + {s2_ph, 16'd0};
			s3_add   <= s2_add;
			s3_tag   <= s2_tag;
			out_data <= s3_prod + s3_add;
			out_tag  <= s3_tag;
		end
	end

	a_tag_hold: assert property (@(posedge clock) disable iff (!rst_n)
		out_valid && !out_take |=> out_valid && $stable(out_tag));

endmodule

/* hw/alu_issue.sv */
`timescale 1ns/1ps

module alu_issue (
	input  logic                          clock,
	input  logic                          rst_n,
	input  logic                          req,
	output logic                          ack,
	input  alu_pkg::alu_op_e              op,
	input  logic [alu_pkg::DATA_W-1:0]    a,
	input  logic [alu_pkg::DATA_W-1:0]    b,
	input  logic [alu_pkg::DATA_W-1:0]    c,
	output logic                          iss_valid,
	input  logic                          iss_ready,
	output alu_pkg::alu_op_e              iss_op,
	output logic [alu_pkg::DATA_W-1:0]    iss_a,
	output logic [alu_pkg::DATA_W-1:0]    iss_b,
	output logic [alu_pkg::DATA_W-1:0]    iss_c,
	output logic [alu_pkg::TAG_W-1:0]     iss_tag
);

	typedef enum logic {IDLE, HOLD} state_e;

	state_e                      state;
	logic [alu_pkg::TAG_W-1:0]   issue_no;  // Wraps

	always_ff @(posedge clock) begin
		if (!rst_n) begin
			state     <= IDLE;
			ack       <= 1'b0;
			iss_valid <= 1'b0;
			issue_no  <= '0;
		end else begin
			if (iss_valid && iss_ready)
				iss_valid <= 1'b0;
			case (state)
				IDLE: begin
					// Only capture into an empty stage
					if (req && !iss_valid) begin
						ack       <= 1'b1;
						iss_valid <= 1'b1;
						issue_no  <= issue_no + 1'b1;
						state     <= HOLD;
					end
				end
				HOLD: begin
					if (!req) begin  // Source done, close the handshake
						ack   <= 1'b0;
						state <= IDLE;
					end
				end
				default: state <= IDLE;
			endcase
		end
	end

	// Operand capture
	always_ff @(posedge clock) begin
		if (state == IDLE && req && !iss_valid) begin
			iss_op  <= op;
			iss_a   <= a;
			iss_b   <= b;
			iss_c   <= c;
			iss_tag <= issue_no;
		end
	end

	a_ack_after_req: assert property (@(posedge clock) disable iff (!rst_n)
		$rose(ack) |-> $past(req));

endmodule

/* hw/alu_pkg.sv */
package alu_pkg;

	//////////////////////////////////////////////////
	// Widths and limits
	//////////////////////////////////////////////////
	localparam int DATA_W        = 32;
	localparam int TAG_W         = 4;
	localparam int MAX_IN_FLIGHT = 8;  // Half the tag range keeps the age compare exact
	localparam int MA_DEPTH      = 4;

	//////////////////////////////////////////////////
	// Opcodes
	//////////////////////////////////////////////////
	// Divide by zero: quotient is all ones, remainder is the dividend
	// Code 4'hF is unused and executes as ADD
	typedef enum logic [3:0] {
		ADD    = 4'h0,
		SUB    = 4'h1,
		MUL    = 4'h2,
		MADD   = 4'h3,  // a * b + c, low word
		DIVU   = 4'h4,
		REMU   = 4'h5,
		SHL    = 4'h6,
		SHR    = 4'h7,
		SRA    = 4'h8,
		ROL    = 4'h9,
		AND    = 4'hA,
		OR     = 4'hB,
		XOR    = 4'hC,
		SEXT_B = 4'hD,
		SEXT_H = 4'hE
	} alu_op_e;

	// Execution unit class
	typedef enum logic [1:0] {
		UNIT_MA  = 2'd0,
		UNIT_DIV = 2'd1,
		UNIT_BIT = 2'd2
	} unit_e;

endpackage
